//--- logic/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Bus and register width
`define DATA_WIDTH 32

// General register file size
`define REG_COUNT 16
`define REG_INDEX_WIDTH 4

// Instruction fields
`define OPCODE_MSB 31
`define OPCODE_LSB 27
`define RA_MSB 26
`define RA_LSB 23
`define RB_MSB 22
`define RB_LSB 19
`define RC_MSB 18
`define RC_LSB 15
// Constant overlaps Rc, sign bit is bit 18
`define CONST_MSB 18
`define CONST_LSB 0

// First fetch address after reset
`define RESET_PC 0

`endif

//--- logic/cpuPkg.sv
package cpuPkg;

  // Instruction opcodes, anything not listed decodes as halt
  typedef enum logic [4:0] {
    ld    = 5'd0,
    st    = 5'd1,
    addi  = 5'd2,
    add   = 5'd3,
    sub   = 5'd4,
    andOp = 5'd5,
    orOp  = 5'd6,
    halt  = 5'd31
  } opcodeT;

  // ALU functions
  typedef enum logic [2:0] {
    aluAdd   = 3'd0,
    aluSub   = 3'd1,
    aluAnd   = 3'd2,
    aluOr    = 3'd3,
    aluPassB = 3'd4
  } aluOpT;

  // Which block drives the internal bus
  typedef enum logic [2:0] {
    srcNone  = 3'd0,
    srcPc    = 3'd1,
    srcMdr   = 3'd2,
    srcReg   = 3'd3,
    srcZ     = 3'd4,
    srcConst = 3'd5
  } busSourceT;

endpackage

//--- logic/registerFile.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module registerFile (
  input  logic                   clock,
  input  logic                   rstN,
  input  logic [`DATA_WIDTH-1:0] ir,
  input  logic                   gra,
  input  logic                   grb,
  input  logic                   grc,
  input  logic                   regIn,
  input  logic                   baOut,
  input  logic [`DATA_WIDTH-1:0] busIn,
  output logic [`DATA_WIDTH-1:0] regOut
);

  logic [`DATA_WIDTH-1:0]     regs [`REG_COUNT];
  logic [`REG_INDEX_WIDTH-1:0] regIndex;

  // Select encode
  // Only one of gra, grb, grc is active per state, so the fields can be OR'ed
  assign regIndex = ({`REG_INDEX_WIDTH{gra}} & ir[`RA_MSB:`RA_LSB]) |
                    ({`REG_INDEX_WIDTH{grb}} & ir[`RB_MSB:`RB_LSB]) |
                    ({`REG_INDEX_WIDTH{grc}} & ir[`RC_MSB:`RC_LSB]);

  // Write port, loads the selected register from the bus
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (regIn) begin
      regs[regIndex] <= busIn;
    end
  end

  // Read port
  // With baOut, R0 reads as zero so a constant becomes an absolute address
  always_comb begin
    if (baOut && (regIndex == '0)) begin
      regOut = '0;
    end else begin
      regOut = regs[regIndex];
    end
  end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module alu (
  input  cpuPkg::aluOpT          aluOp,
  input  logic [`DATA_WIDTH-1:0] a,
  input  logic [`DATA_WIDTH-1:0] b,
  output logic [`DATA_WIDTH-1:0] result
);

  // a comes from Y, b from the bus or the sign-extended constant
  always_comb begin
    case (aluOp)
      cpuPkg::aluAdd: begin
        // Carry out is dropped, plain 32-bit wraparound
        result = a + b;
      end
      cpuPkg::aluSub: begin
        result = a - b;
      end
      cpuPkg::aluAnd: begin
        result = a & b;
      end
      cpuPkg::aluOr: begin
        result = a | b;
      end
      cpuPkg::aluPassB: begin
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- logic/memoryInterface.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module memoryInterface (
  input  logic                   clock,
  input  logic                   rstN,
  input  logic [`DATA_WIDTH-1:0] busIn,
  input  logic                   marIn,
  input  logic                   mdrIn,
  input  logic                   memRead,
  input  logic                   memWrite,
  output logic [`DATA_WIDTH-1:0] mdrOut,
  output logic                   memDone,
  output logic [`DATA_WIDTH-1:0] wbAdr,
  output logic [`DATA_WIDTH-1:0] wbDatOut,
  output logic                   wbWe,
  output logic                   wbCyc,
  output logic                   wbStb,
  input  logic [`DATA_WIDTH-1:0] wbDatIn,
  input  logic                   wbAck
);

  typedef enum logic [1:0] {
    memIdle,
    memActive,
    memFinish
  } memStateT;

  memStateT               state;
  logic [`DATA_WIDTH-1:0] mar;
  logic [`DATA_WIDTH-1:0] mdr;
  logic                   request;
  logic                   cycleOn;

  assign request = memRead | memWrite;

  // Cycle starts in the same clock the request shows up in idle
  // MAR and MDR were loaded in an earlier state, so they are already stable
  assign cycleOn = ((state == memIdle) && request) || (state == memActive);

  // Fixed-rate slave would see one-cycle strobes; slower ones stretch memActive
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      state <= memIdle;
    end else begin
      case (state)
        memIdle: begin
          if (request) begin
            state <= wbAck ? memFinish : memActive;
          end
        end
        memActive: begin
          if (wbAck) begin
            state <= memFinish;
          end
        end
        default: begin
          // memFinish lasts one clock, the control unit moves on with it
          state <= memIdle;
        end
      endcase
    end
  end

  // Address and data registers
  always_ff @(posedge clock) begin
    if (marIn) begin
      mar <= busIn;
    end
    if (cycleOn && wbAck && memRead) begin
      mdr <= wbDatIn;
    end else if (mdrIn) begin
      mdr <= busIn;
    end
  end

  assign memDone  = (state == memFinish);
  assign mdrOut   = mdr;
  assign wbAdr    = mar;
  assign wbDatOut = mdr;
  assign wbCyc    = cycleOn;
  assign wbStb    = cycleOn;
  // memWrite is held for the whole access
  assign wbWe     = cycleOn & memWrite;

endmodule

//--- logic/datapath.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module datapath (
  input  logic                   clock,
  input  logic                   rstN,
  input  cpuPkg::busSourceT      busSource,
  input  logic                   pcIn,
  input  logic                   irIn,
  input  logic                   yIn,
  input  logic                   zIn,
  input  logic                   marIn,
  input  logic                   mdrIn,
  input  logic                   regIn,
  input  logic                   incPc,
  input  logic                   immSel,
  input  cpuPkg::aluOpT          aluOp,
  input  logic                   gra,
  input  logic                   grb,
  input  logic                   grc,
  input  logic                   baOut,
  input  logic                   memRead,
  input  logic                   memWrite,
  output cpuPkg::opcodeT         opcode,
  output logic                   memDone,
  output logic [`DATA_WIDTH-1:0] wbAdr,
  output logic [`DATA_WIDTH-1:0] wbDatOut,
  output logic                   wbWe,
  output logic                   wbCyc,
  output logic                   wbStb,
  input  logic [`DATA_WIDTH-1:0] wbDatIn,
  input  logic                   wbAck
);

  logic [`DATA_WIDTH-1:0] bus;
  logic [`DATA_WIDTH-1:0] pc;
  logic [`DATA_WIDTH-1:0] ir;
  logic [`DATA_WIDTH-1:0] y;
  logic [`DATA_WIDTH-1:0] z;
  logic [`DATA_WIDTH-1:0] constExt;
  logic [`DATA_WIDTH-1:0] aluB;
  logic [`DATA_WIDTH-1:0] aluResult;
  logic [`DATA_WIDTH-1:0] regOut;
  logic [`DATA_WIDTH-1:0] mdrOut;

  // C field sign-extended to full width
  assign constExt = {{(`DATA_WIDTH - `CONST_MSB - 1){ir[`CONST_MSB]}},
                     ir[`CONST_MSB:`CONST_LSB]};

  // Single shared bus
  always_comb begin
    case (busSource)
      cpuPkg::srcPc:    bus = pc;
      cpuPkg::srcMdr:   bus = mdrOut;
      cpuPkg::srcReg:   bus = regOut;
      cpuPkg::srcZ:     bus = z;
      cpuPkg::srcConst: bus = constExt;
      default:          bus = '0;
    endcase
  end

  // PC steps one word while it is on the bus in T0
  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      pc <= `DATA_WIDTH'(`RESET_PC);
    end else if (pcIn) begin
      pc <= bus;
    end else if (incPc) begin
      pc <= pc + 1'b1;
    end
  end

  // IR, Y and Z only hold operands between states
  always_ff @(posedge clock) begin
    if (irIn) begin
      ir <= bus;
    end
    if (yIn) begin
      y <= bus;
    end
    if (zIn) begin
      z <= aluResult;
    end
  end

  assign opcode = cpuPkg::opcodeT'(ir[`OPCODE_MSB:`OPCODE_LSB]);

  // Immediate forms take the constant in place of the bus
  assign aluB = immSel ? constExt : bus;

  registerFile i_registerFile (
    .clock  (clock),
    .rstN   (rstN),
    .ir     (ir),
    .gra    (gra),
    .grb    (grb),
    .grc    (grc),
    .regIn  (regIn),
    .baOut  (baOut),
    .busIn  (bus),
    .regOut (regOut)
  );

  alu i_alu (
    .aluOp  (aluOp),
    .a      (y),
    .b      (aluB),
    .result (aluResult)
  );

  memoryInterface i_memoryInterface (
    .clock    (clock),
    .rstN     (rstN),
    .busIn    (bus),
    .marIn    (marIn),
    .mdrIn    (mdrIn),
    .memRead  (memRead),
    .memWrite (memWrite),
    .mdrOut   (mdrOut),
    .memDone  (memDone),
    .wbAdr    (wbAdr),
    .wbDatOut (wbDatOut),
    .wbWe     (wbWe),
    .wbCyc    (wbCyc),
    .wbStb    (wbStb),
    .wbDatIn  (wbDatIn),
    .wbAck    (wbAck)
  );

endmodule

//--- logic/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
  input  logic              clock,
  input  logic              rstN,
  input  logic              memDone,
  input  cpuPkg::opcodeT    opcode,
  output cpuPkg::busSourceT busSource,
  output logic              pcIn,
  output logic              irIn,
  output logic              yIn,
  output logic              zIn,
  output logic              marIn,
  output logic              mdrIn,
  output logic              regIn,
  output logic              incPc,
  output logic              immSel,
  output cpuPkg::aluOpT     aluOp,
  output logic              gra,
  output logic              grb,
  output logic              grc,
  output logic              baOut,
  output logic              memRead,
  output logic              memWrite,
  output logic              halted
);

  typedef enum logic [3:0] {
    t0, t1, t2, t3, t4, t5, t6, t7, tHalt
  } stateT;

  stateT state;
  stateT nextState;
  logic  validOp;
  logic  memOp;
  logic  immOp;

  // Opcode is valid from T3 on, IR loads at the end of T2
  assign validOp = opcode inside {cpuPkg::ld, cpuPkg::st, cpuPkg::addi, cpuPkg::add,
                                  cpuPkg::sub, cpuPkg::andOp, cpuPkg::orOp};
  assign memOp   = (opcode == cpuPkg::ld) || (opcode == cpuPkg::st);
  assign immOp   = memOp || (opcode == cpuPkg::addi);

  always_ff @(posedge clock or negedge rstN) begin
    if (!rstN) begin
      state <= t0;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    busSource = cpuPkg::srcNone;
    // No instruction in this set loads PC from the bus
    pcIn      = 1'b0;
    irIn      = 1'b0;
    yIn       = 1'b0;
    zIn       = 1'b0;
    marIn     = 1'b0;
    mdrIn     = 1'b0;
    regIn     = 1'b0;
    incPc     = 1'b0;
    immSel    = 1'b0;
    aluOp     = cpuPkg::aluAdd;
    gra       = 1'b0;
    grb       = 1'b0;
    grc       = 1'b0;
    baOut     = 1'b0;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    case (state)
      t0: begin
        busSource = cpuPkg::srcPc;
        marIn     = 1'b1;
        incPc     = 1'b1;
        nextState = t1;
      end
      t1: begin
        // Instruction fetch, hold until the bus cycle finishes
        memRead = 1'b1;
        if (memDone) begin
          nextState = t2;
        end
      end
      t2: begin
        busSource = cpuPkg::srcMdr;
        irIn      = 1'b1;
        nextState = t3;
      end
      t3: begin
        if (validOp) begin
          busSource = cpuPkg::srcReg;
          grb       = 1'b1;
          // Base register R0 means absolute address
          baOut     = memOp;
          yIn       = 1'b1;
          nextState = t4;
        end else begin
          nextState = tHalt;
        end
      end
      t4: begin
        zIn       = 1'b1;
        nextState = t5;
        if (immOp) begin
          immSel = 1'b1;
        end else begin
          busSource = cpuPkg::srcReg;
          grc       = 1'b1;
          case (opcode)
            cpuPkg::sub:   aluOp = cpuPkg::aluSub;
            cpuPkg::andOp: aluOp = cpuPkg::aluAnd;
            cpuPkg::orOp:  aluOp = cpuPkg::aluOr;
            default:       aluOp = cpuPkg::aluAdd;
          endcase
        end
      end
      t5: begin
        busSource = cpuPkg::srcZ;
        if (memOp) begin
          // Effective address
          marIn     = 1'b1;
          nextState = t6;
        end else begin
          gra       = 1'b1;
          regIn     = 1'b1;
          nextState = t0;
        end
      end
      t6: begin
        if (opcode == cpuPkg::ld) begin
          memRead = 1'b1;
          if (memDone) begin
            nextState = t7;
          end
        end else begin
          // Store data goes Ra to MDR
          busSource = cpuPkg::srcReg;
          gra       = 1'b1;
          mdrIn     = 1'b1;
          nextState = t7;
        end
      end
      t7: begin
        if (opcode == cpuPkg::ld) begin
          busSource = cpuPkg::srcMdr;
          gra       = 1'b1;
          regIn     = 1'b1;
          nextState = t0;
        end else begin
          memWrite = 1'b1;
          if (memDone) begin
            nextState = t0;
          end
        end
      end
      default: begin
        // Halted, only reset leaves this state
        nextState = tHalt;
      end
    endcase
  end

  assign halted = (state == tHalt);

endmodule

//--- logic/cpuTop.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuTop (
  input  logic                   clock,
  input  logic                   rstN,
  output logic [`DATA_WIDTH-1:0] wbAdr,
  output logic [`DATA_WIDTH-1:0] wbDatOut,
  output logic                   wbWe,
  output logic                   wbCyc,
  output logic                   wbStb,
  input  logic [`DATA_WIDTH-1:0] wbDatIn,
  input  logic                   wbAck,
  output logic                   halted
);

  // Control to datapath
  cpuPkg::busSourceT busSource;
  cpuPkg::aluOpT     aluOp;
  cpuPkg::opcodeT    opcode;
  logic              pcIn;
  logic              irIn;
  logic              yIn;
  logic              zIn;
  logic              marIn;
  logic              mdrIn;
  logic              regIn;
  logic              incPc;
  logic              immSel;
  logic              gra;
  logic              grb;
  logic              grc;
  logic              baOut;
  logic              memRead;
  logic              memWrite;
  logic              memDone;

  controlUnit i_controlUnit (
    .clock     (clock),
    .rstN      (rstN),
    .memDone   (memDone),
    .opcode    (opcode),
    .busSource (busSource),
    .pcIn      (pcIn),
    .irIn      (irIn),
    .yIn       (yIn),
    .zIn       (zIn),
    .marIn     (marIn),
    .mdrIn     (mdrIn),
    .regIn     (regIn),
    .incPc     (incPc),
    .immSel    (immSel),
    .aluOp     (aluOp),
    .gra       (gra),
    .grb       (grb),
    .grc       (grc),
    .baOut     (baOut),
    .memRead   (memRead),
    .memWrite  (memWrite),
    .halted    (halted)
  );

  datapath i_datapath (
    .clock     (clock),
    .rstN      (rstN),
    .busSource (busSource),
    .pcIn      (pcIn),
    .irIn      (irIn),
    .yIn       (yIn),
    .zIn       (zIn),
    .marIn     (marIn),
    .mdrIn     (mdrIn),
    .regIn     (regIn),
    .incPc     (incPc),
    .immSel    (immSel),
    .aluOp     (aluOp),
    .gra       (gra),
    .grb       (grb),
    .grc       (grc),
    .baOut     (baOut),
    .memRead   (memRead),
    .memWrite  (memWrite),
    .opcode    (opcode),
    .memDone   (memDone),
    .wbAdr     (wbAdr),
    .wbDatOut  (wbDatOut),
    .wbWe      (wbWe),
    .wbCyc     (wbCyc),
    .wbStb     (wbStb),
    .wbDatIn   (wbDatIn),
    .wbAck     (wbAck)
  );

endmodule

//--- tests/cpuTop_chk.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuTop_chk (
  input logic                   clock,
  input logic                   rstN,
  input logic [`DATA_WIDTH-1:0] wbAdr,
  input logic [`DATA_WIDTH-1:0] wbDatOut,
  input logic                   wbWe,
  input logic                   wbCyc,
  input logic                   wbStb,
  input logic                   wbAck,
  input logic                   halted
);

  // Strobe only inside a bus cycle
  stbInCycle: assert property (@(posedge clock) disable iff (!rstN) wbStb |-> wbCyc)
    else $error("wbStb high while wbCyc is low");

  // Request held unchanged until the slave acks
  requestHeld: assert property (@(posedge clock) disable iff (!rstN)
    (wbStb && !wbAck) |=>
      (wbStb && $stable(wbAdr) && $stable(wbWe) && $stable(wbDatOut)))
    else $error("Wishbone request changed or dropped before ack");

  // Only reset leaves the halted state
  haltSticky: assert property (@(posedge clock) disable iff (!rstN) halted |=> halted)
    else $error("halted dropped without reset");

  // no bus traffic once halted
  quietWhenHalted: assert property (@(posedge clock) disable iff (!rstN) halted |-> !wbStb)
    else $error("bus strobe while halted");

endmodule

bind cpuTop cpuTop_chk i_cpuTop_chk (
  .clock    (clock),
  .rstN     (rstN),
  .wbAdr    (wbAdr),
  .wbDatOut (wbDatOut),
  .wbWe     (wbWe),
  .wbCyc    (wbCyc),
  .wbStb    (wbStb),
  .wbAck    (wbAck),
  .halted   (halted)
);

//--- tests/cpuTop_tb.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpuTop_tb;

  localparam int CLOCK_PERIOD    = 20;
  localparam int RESET_CYCLES    = 8;
  localparam int MEM_WORDS       = 256;
  localparam int TEST_COUNT      = 5;
  localparam int CYCLES_PER_TEST = 200;
  // Bus is watched this long after halt
  localparam int QUIET_CYCLES    = 10;

  logic                   clock = 1'b0;
  logic                   rstN;
  logic [`DATA_WIDTH-1:0] wbAdr;
  logic [`DATA_WIDTH-1:0] wbDatOut;
  logic [`DATA_WIDTH-1:0] wbDatIn;
  logic                   wbWe;
  logic                   wbCyc;
  logic                   wbStb;
  logic                   wbAck;
  logic                   halted;

  // Slave memory and its access state
  logic [`DATA_WIDTH-1:0] mem [MEM_WORDS];
  logic                   randomWaits;
  logic                   accessOpen;
  int                     waitLeft;
  int                     writeCount;
  integer                 seed;
  int                     loadAddr;
  // Results of the zero-wait ALU run
  logic [`DATA_WIDTH-1:0] aluRef [4];

  cpuTop i_cpuTop (
    .clock    (clock),
    .rstN     (rstN),
    .wbAdr    (wbAdr),
    .wbDatOut (wbDatOut),
    .wbWe     (wbWe),
    .wbCyc    (wbCyc),
    .wbStb    (wbStb),
    .wbDatIn  (wbDatIn),
    .wbAck    (wbAck),
    .halted   (halted)
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  // Background word, every address bit shows up in it
  function automatic logic [`DATA_WIDTH-1:0] fillWord(input int addr);
    logic [7:0] a;
    a = addr[7:0];
    return {a ^ 8'h5A, 8'hC3, ~a, a};
  endfunction

  // ld, st and addi format: opcode, Ra, Rb, 19-bit constant
  function automatic logic [`DATA_WIDTH-1:0] immInstr(input cpuPkg::opcodeT op,
                                                      input int ra, input int rb,
                                                      input int c);
    logic [`DATA_WIDTH-1:0] w;
    w = '0;
    w[`OPCODE_MSB:`OPCODE_LSB] = op;
    w[`RA_MSB:`RA_LSB] = ra[`REG_INDEX_WIDTH-1:0];
    w[`RB_MSB:`RB_LSB] = rb[`REG_INDEX_WIDTH-1:0];
    w[`CONST_MSB:`CONST_LSB] = c[`CONST_MSB:0];
    return w;
  endfunction

  // Three-register format, Ra gets Rb op Rc
  function automatic logic [`DATA_WIDTH-1:0] regInstr(input cpuPkg::opcodeT op,
                                                      input int ra, input int rb,
                                                      input int rc);
    logic [`DATA_WIDTH-1:0] w;
    w = '0;
    w[`OPCODE_MSB:`OPCODE_LSB] = op;
    w[`RA_MSB:`RA_LSB] = ra[`REG_INDEX_WIDTH-1:0];
    w[`RB_MSB:`RB_LSB] = rb[`REG_INDEX_WIDTH-1:0];
    w[`RC_MSB:`RC_LSB] = rc[`REG_INDEX_WIDTH-1:0];
    return w;
  endfunction

  function automatic logic [`DATA_WIDTH-1:0] haltInstr();
    logic [`DATA_WIDTH-1:0] w;
    w = '0;
    w[`OPCODE_MSB:`OPCODE_LSB] = cpuPkg::halt;
    return w;
  endfunction

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic compareWord(input string what, input logic [`DATA_WIDTH-1:0] actual,
                             input logic [`DATA_WIDTH-1:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, actual,
               expected);
      $display("test failed");
      $fatal(1);
    end
  endtask

  // Reset goes low here, memory gets the background pattern
  task automatic beginTest(input logic waits);
    @(negedge clock);
    rstN = 1'b0;
    randomWaits = waits;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fillWord(i);
    end
    loadAddr = 0;
  endtask

  // Program words go in from address 0 upward
  task automatic emit(input logic [`DATA_WIDTH-1:0] word);
    mem[loadAddr] = word;
    loadAddr++;
  endtask

  task automatic runUntilHalted();
    repeat (RESET_CYCLES) @(negedge clock);
    rstN = 1'b1;
    @(negedge clock);
    while (!halted) begin
      @(negedge clock);
    end
  endtask

  // Wishbone slave, answers on falling edges
  // Ack delay is counted in falling edges after stb is seen
  always @(negedge clock) begin
    if (wbAck) begin
      wbAck = 1'b0;
      accessOpen = 1'b0;
    end else if (wbCyc && wbStb) begin
      if (!accessOpen) begin
        accessOpen = 1'b1;
        waitLeft = randomWaits ? ($random(seed) & 3) : 0;
      end
      if (waitLeft > 0) begin
        waitLeft--;
      end else if (wbAdr >= MEM_WORDS) begin
        abortRun($sformatf("Wishbone address %h is outside the memory model", wbAdr));
      end else begin
        if (wbWe) begin
          mem[wbAdr[7:0]] = wbDatOut;
          writeCount++;
        end else begin
          wbDatIn = mem[wbAdr[7:0]];
        end
        wbAck = 1'b1;
      end
    end
  end

  task automatic absoluteLoadStore();
    logic [`DATA_WIDTH-1:0] source;
    beginTest(1'b0);
    // R0 becomes 5, ld and st still treat it as zero base
    emit(immInstr(cpuPkg::addi, 0, 0, 5));
    emit(immInstr(cpuPkg::ld, 1, 0, 'h80));
    emit(immInstr(cpuPkg::st, 1, 0, 'h88));
    emit(haltInstr());
    source = mem['h80];
    runUntilHalted();
    compareWord("absolute store of loaded word", mem['h88], source);
    compareWord("word at R0 plus constant", mem['h8D], fillWord('h8D));
  endtask

  task automatic basedLoad();
    int                     base;
    int                     offset;
    int                     target;
    logic [`DATA_WIDTH-1:0] source;
    base   = 'h95;
    offset = -5;
    // Negative constant must reach below the base
    target = base + offset;
    beginTest(1'b0);
    emit(immInstr(cpuPkg::addi, 2, 0, base));
    emit(immInstr(cpuPkg::ld, 3, 2, offset));
    emit(immInstr(cpuPkg::st, 3, 0, 'hA0));
    emit(immInstr(cpuPkg::st, 2, 0, 'hA1));
    emit(haltInstr());
    source = mem[target];
    runUntilHalted();
    compareWord("ld through negative offset", mem['hA0], source);
    compareWord("addi result", mem['hA1], 32'(base));
  endtask

  // Two operands, four results at 0x90 to 0x93
  task automatic runAluProgram(input logic waits);
    logic [`DATA_WIDTH-1:0] a;
    logic [`DATA_WIDTH-1:0] b;
    // Sum carries out of bit 31
    a = 32'hF000_0001;
    b = 32'h1000_0003;
    beginTest(waits);
    mem['h80] = a;
    mem['h81] = b;
    emit(immInstr(cpuPkg::ld, 1, 0, 'h80));
    emit(immInstr(cpuPkg::ld, 2, 0, 'h81));
    emit(regInstr(cpuPkg::add, 3, 1, 2));
    emit(regInstr(cpuPkg::sub, 4, 1, 2));
    emit(regInstr(cpuPkg::andOp, 5, 1, 2));
    emit(regInstr(cpuPkg::orOp, 6, 1, 2));
    for (int r = 3; r <= 6; r++) begin
      emit(immInstr(cpuPkg::st, r, 0, 'h90 + r - 3));
    end
    emit(haltInstr());
    runUntilHalted();
    compareWord("add result", mem['h90], a + b);
    compareWord("sub result", mem['h91], a - b);
    compareWord("and result", mem['h92], a & b);
    compareWord("or result", mem['h93], a | b);
  endtask

  task automatic aluOperations();
    runAluProgram(1'b0);
    for (int i = 0; i < 4; i++) begin
      aluRef[i] = mem['h90 + i];
    end
  endtask

  task automatic haltStopsWrites();
    int writesAtHalt;
    beginTest(1'b0);
    emit(immInstr(cpuPkg::ld, 1, 0, 'h80));
    emit(immInstr(cpuPkg::st, 1, 0, 'h90));
    emit(haltInstr());
    // Stores past the halt, never executed
    emit(immInstr(cpuPkg::st, 1, 0, 'h91));
    emit(immInstr(cpuPkg::st, 1, 0, 'h92));
    runUntilHalted();
    writesAtHalt = writeCount;
    repeat (QUIET_CYCLES) @(negedge clock);
    compareWord("halted output", 32'(halted), 32'd1);
    compareWord("bus writes after halt", writeCount, writesAtHalt);
    compareWord("store before halt", mem['h90], mem['h80]);
    compareWord("word 0x91 after halt", mem['h91], fillWord('h91));
    compareWord("word 0x92 after halt", mem['h92], fillWord('h92));
    compareWord("instruction after halt", mem[3], immInstr(cpuPkg::st, 1, 0, 'h91));
    compareWord("second instruction after halt", mem[4],
                immInstr(cpuPkg::st, 1, 0, 'h92));
  endtask

  // ALU program again, slave now stalls 0 to 3 cycles per access
  task automatic waitStates();
    runAluProgram(1'b1);
    for (int i = 0; i < 4; i++) begin
      compareWord("result with wait states", mem['h90 + i], aluRef[i]);
    end
  endtask

  // Watchdog
  initial begin
    #(TEST_COUNT * CYCLES_PER_TEST * CLOCK_PERIOD);
    abortRun("timeout: halted never rose within the cycle budget");
  end

  initial begin
    rstN        = 1'b0;
    wbAck       = 1'b0;
    wbDatIn     = '0;
    randomWaits = 1'b0;
    accessOpen  = 1'b0;
    waitLeft    = 0;
    writeCount  = 0;
    loadAddr    = 0;
    seed        = 32;
    absoluteLoadStore();
    basedLoad();
    aluOperations();
    haltStopsWrites();
    waitStates();
    $display("test passed");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+logic
logic/cpuPkg.sv
logic/registerFile.sv
logic/alu.sv
logic/memoryInterface.sv
logic/datapath.sv
logic/controlUnit.sv
logic/cpuTop.sv
tests/cpuTop_chk.sv
tests/cpuTop_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the cpuTop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module cpuTop_tb \
  -o cpuTop_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/cpuTop_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit $status
fi
exit 0
